// ==== source/pd_pkg.sv ====
package pd_pkg;

    // Step spacing in aon clock cycles
    typedef logic [3:0] seq_delay_t;

    // AXI4-Lite register space
    typedef logic [3:0]  axil_addr_t;
    typedef logic [31:0] axil_data_t;

    typedef enum logic [2:0] {
        SEL_CLK_EN,
        SEL_ISO,
        SEL_RET,
        SEL_RSTN,
        SEL_PWR_REQ
    } pd_ctrl_sel_t;

    typedef struct packed {
        pd_ctrl_sel_t sel;   // Control touched by this step
        logic         level; // New level for it
        seq_delay_t   delay;
        logic         last;  // Final step of a transition
    } pd_step_t;

    typedef enum logic [1:0] {
        MODE_OFF,
        MODE_GOING_ON,
        MODE_ON,
        MODE_GOING_OFF
    } pd_mode_t;

    localparam axil_addr_t REG_CTRL   = 4'h0; // bit0 sleep, bit1 wake
    localparam axil_addr_t REG_DELAY  = 4'h4; // [3:0] off, [7:4] on
    localparam axil_addr_t REG_STATUS = 4'h8; // [1:0] mode, read only

endpackage

// ==== source/pd_step_if.sv ====
`timescale 1ns/1ps

interface pd_step_if import pd_pkg::*; ();

    logic     valid;
    logic     ready;
    pd_step_t step;

    // Sender side
    modport producer (
        output valid,
        output step,
        input  ready
    );

    // Receiver side
    modport consumer (
        input  valid,
        input  step,
        output ready
    );

endinterface

// ==== source/pd_csr_axil.sv ====
`timescale 1ns/1ps

module pd_csr_axil import pd_pkg::*; (
    input  logic       i_aon_clk,
    input  logic       i_soc_pwr_on_rst,

    input  axil_addr_t i_awaddr,
    input  logic       i_awvalid,
    output logic       o_awready,
    input  axil_data_t i_wdata,
    input  logic       i_wvalid,
    output logic       o_wready,
    output logic [1:0] o_bresp,
    output logic       o_bvalid,
    input  logic       i_bready,
    input  axil_addr_t i_araddr,
    input  logic       i_arvalid,
    output logic       o_arready,
    output axil_data_t o_rdata,
    output logic [1:0] o_rresp,
    output logic       o_rvalid,
    input  logic       i_rready,

    input  pd_mode_t   i_mode,
    output logic       o_sleep_pulse,
    output logic       o_wake_pulse,
    output seq_delay_t o_off_delay,
    output seq_delay_t o_on_delay
);

    logic       wr_fire;
    logic       rd_fire;
    axil_data_t rd_word;

    // AW and W only go together, a lone valid sees its ready drop
    assign o_awready = ~o_bvalid & ~(i_awvalid & ~i_wvalid);
    assign o_wready  = ~o_bvalid & ~(i_wvalid & ~i_awvalid);
    assign o_arready = ~o_rvalid;

    assign wr_fire = i_awvalid & i_wvalid & ~o_bvalid;
    assign rd_fire = i_arvalid & ~o_rvalid;

    assign o_bresp = 2'b00; // Always OKAY
    assign o_rresp = 2'b00;

    // Write side and request pulses
    always_ff @(posedge i_aon_clk or posedge i_soc_pwr_on_rst) begin
        if (i_soc_pwr_on_rst) begin
            o_bvalid      <= 1'b0;
            o_sleep_pulse <= 1'b0;
            o_wake_pulse  <= 1'b0;
            o_off_delay   <= '0;
            o_on_delay    <= '0;
        end else begin
            o_sleep_pulse <= wr_fire && (i_awaddr == REG_CTRL) && i_wdata[0];
            o_wake_pulse  <= wr_fire && (i_awaddr == REG_CTRL) && i_wdata[1];

            if (wr_fire && (i_awaddr == REG_DELAY)) begin
                o_off_delay <= i_wdata[3:0];
                o_on_delay  <= i_wdata[7:4];
            end

            if (wr_fire) begin
                o_bvalid <= 1'b1;
            end else if (i_bready) begin
                o_bvalid <= 1'b0;
            end
        end
    end

    // Readback mux, CTRL is write only
    always_comb begin
        rd_word = '0;
        case (i_araddr)
            REG_DELAY:  rd_word = {24'd0, o_on_delay, o_off_delay};
            REG_STATUS: rd_word = {30'd0, i_mode};
            default:    rd_word = '0;
        endcase
    end

    always_ff @(posedge i_aon_clk or posedge i_soc_pwr_on_rst) begin
        if (i_soc_pwr_on_rst) begin
            o_rvalid <= 1'b0;
        end else if (rd_fire) begin
            o_rvalid <= 1'b1;
        end else if (i_rready) begin
            o_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge i_aon_clk) begin
        if (rd_fire) begin
            o_rdata <= rd_word;
        end
    end

endmodule

// ==== source/pd_mode_fsm.sv ====
`timescale 1ns/1ps

module pd_mode_fsm import pd_pkg::*; (
    input  logic       i_aon_clk,
    input  logic       i_soc_pwr_on_rst,
    input  logic       i_sleep_pulse,
    input  logic       i_wake_pulse,
    input  seq_delay_t i_off_delay,
    input  seq_delay_t i_on_delay,
    output pd_mode_t   o_mode,
    input  logic       i_seq_done,
    pd_step_if.producer step_if
);

    localparam logic [2:0] LAST_IDX = 3'd4;
    localparam logic [2:0] DONE_IDX = 3'd5; // All five steps pushed

    logic [2:0]   step_idx;
    seq_delay_t   step_delay;
    logic         going;
    logic         push_fire;
    pd_ctrl_sel_t step_sel;
    logic         step_lvl;

    assign going     = (o_mode == MODE_GOING_ON) || (o_mode == MODE_GOING_OFF);
    assign push_fire = step_if.valid & step_if.ready;

    always_ff @(posedge i_aon_clk or posedge i_soc_pwr_on_rst) begin
        if (i_soc_pwr_on_rst) begin
            o_mode   <= MODE_OFF;
            step_idx <= '0;
        end else begin
            case (o_mode)
                MODE_OFF: if (i_wake_pulse) begin
                    o_mode   <= MODE_GOING_ON;
                    step_idx <= '0;
                end
                MODE_ON: if (i_sleep_pulse) begin
                    o_mode   <= MODE_GOING_OFF;
                    step_idx <= '0;
                end
                MODE_GOING_ON: begin
                    if (push_fire) step_idx <= step_idx + 3'd1;
                    if (i_seq_done) o_mode <= MODE_ON;
                end
                default: begin // Going off
                    if (push_fire) step_idx <= step_idx + 3'd1;
                    if (i_seq_done) o_mode <= MODE_OFF;
                end
            endcase
        end
    end

    // Delay fixed for the whole transition
    always_ff @(posedge i_aon_clk) begin
        if ((o_mode == MODE_OFF) && i_wake_pulse) begin
            step_delay <= i_on_delay;
        end else if ((o_mode == MODE_ON) && i_sleep_pulse) begin
            step_delay <= i_off_delay;
        end
    end

    always_comb begin
        step_sel = SEL_CLK_EN;
        step_lvl = 1'b0;
        if (o_mode == MODE_GOING_ON) begin
            case (step_idx)
                3'd0:    begin step_sel = SEL_PWR_REQ; step_lvl = 1'b1; end
                3'd1:    begin step_sel = SEL_RSTN;    step_lvl = 1'b1; end
                3'd2:    begin step_sel = SEL_RET;     step_lvl = 1'b0; end
                3'd3:    begin step_sel = SEL_ISO;     step_lvl = 1'b0; end
                default: begin step_sel = SEL_CLK_EN;  step_lvl = 1'b1; end
            endcase
        end else begin
            case (step_idx)
                3'd0:    begin step_sel = SEL_CLK_EN;  step_lvl = 1'b0; end
                3'd1:    begin step_sel = SEL_ISO;     step_lvl = 1'b1; end
                3'd2:    begin step_sel = SEL_RET;     step_lvl = 1'b1; end
                3'd3:    begin step_sel = SEL_RSTN;    step_lvl = 1'b0; end
                default: begin step_sel = SEL_PWR_REQ; step_lvl = 1'b0; end
            endcase
        end
    end

    assign step_if.valid      = going && (step_idx != DONE_IDX);
    assign step_if.step.sel   = step_sel;
    assign step_if.step.level = step_lvl;
    assign step_if.step.delay = step_delay;
    assign step_if.step.last  = (step_idx == LAST_IDX);

endmodule

// ==== source/pd_step_fifo.sv ====
`timescale 1ns/1ps

module pd_step_fifo import pd_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic        i_aon_clk,
    input  logic        i_soc_pwr_on_rst,
    pd_step_if.consumer in_if,
    pd_step_if.producer out_if
);

    localparam int             PTR_W    = $clog2(FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_CNT = FIFO_DEPTH[PTR_W:0];

    pd_step_t         mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    assign in_if.ready  = (count != FULL_CNT);
    assign out_if.valid = (count != '0);
    assign out_if.step  = mem[rd_ptr];

    assign push = in_if.valid & in_if.ready;
    assign pop  = out_if.valid & out_if.ready;

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge i_aon_clk or posedge i_soc_pwr_on_rst) begin
        if (i_soc_pwr_on_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge i_aon_clk) begin
        if (push) mem[wr_ptr] <= in_if.step;
    end

endmodule

// ==== source/pd_seq_delay.sv ====
`timescale 1ns/1ps

module pd_seq_delay import pd_pkg::*; (
    input  logic        i_aon_clk,
    input  logic        i_soc_pwr_on_rst,
    pd_step_if.consumer step_if,
    input  logic        i_pwr_on_ack,
    output logic        o_clk_en,
    output logic        o_iso,
    output logic        o_ret,
    output logic        o_rstn,
    output logic        o_pwr_on_req,
    output logic        o_seq_done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_COUNT,
        S_APPLY,
        S_ACK_WAIT
    } seq_state_t;

    seq_state_t state;
    seq_delay_t cnt;
    pd_step_t   cur_step; // Step being applied

    assign step_if.ready = (state == S_IDLE);

    always_ff @(posedge i_aon_clk or posedge i_soc_pwr_on_rst) begin
        if (i_soc_pwr_on_rst) begin
            state        <= S_IDLE;
            cnt          <= '0;
            o_clk_en     <= 1'b0;
            o_iso        <= 1'b1; // Domain starts off and clamped
            o_ret        <= 1'b1;
            o_rstn       <= 1'b0;
            o_pwr_on_req <= 1'b0;
            o_seq_done   <= 1'b0;
        end else begin
            o_seq_done <= 1'b0;
            case (state)
                S_IDLE: if (step_if.valid) begin
                    cnt   <= step_if.step.delay;
                    state <= (step_if.step.delay == '0) ? S_APPLY : S_COUNT;
                end
                S_COUNT: begin
                    cnt <= cnt - 1'b1;
                    if (cnt == 4'd1) state <= S_APPLY;
                end
                S_APPLY: begin
                    case (cur_step.sel)
                        SEL_CLK_EN: o_clk_en     <= cur_step.level;
                        SEL_ISO:    o_iso        <= cur_step.level;
                        SEL_RET:    o_ret        <= cur_step.level;
                        SEL_RSTN:   o_rstn       <= cur_step.level;
                        default:    o_pwr_on_req <= cur_step.level;
                    endcase
                    if (cur_step.sel == SEL_PWR_REQ) begin
                        state <= S_ACK_WAIT; // Switch must settle first
                    end else begin
                        o_seq_done <= cur_step.last;
                        state      <= S_IDLE;
                    end
                end
                default: if (i_pwr_on_ack == cur_step.level) begin
                    o_seq_done <= cur_step.last;
                    state      <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_aon_clk) begin
        if (step_if.valid && step_if.ready) cur_step <= step_if.step;
    end

endmodule

// ==== source/pd_ctrl_top.sv ====
`timescale 1ns/1ps

module pd_ctrl_top import pd_pkg::*; #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic       i_aon_clk,
    input  logic       i_soc_pwr_on_rst,

    input  axil_addr_t i_awaddr,
    input  logic       i_awvalid,
    output logic       o_awready,
    input  axil_data_t i_wdata,
    input  logic       i_wvalid,
    output logic       o_wready,
    output logic [1:0] o_bresp,
    output logic       o_bvalid,
    input  logic       i_bready,
    input  axil_addr_t i_araddr,
    input  logic       i_arvalid,
    output logic       o_arready,
    output axil_data_t o_rdata,
    output logic [1:0] o_rresp,
    output logic       o_rvalid,
    input  logic       i_rready,

    input  logic       i_pwr_on_ack,
    output logic       o_clk_en,
    output logic       o_iso,
    output logic       o_ret,
    output logic       o_rstn,
    output logic       o_pwr_on_req
);

    logic       sleep_pulse;
    logic       wake_pulse;
    seq_delay_t off_delay;
    seq_delay_t on_delay;
    pd_mode_t   mode;
    logic       seq_done;

    pd_step_if push_if ();  // FSM to FIFO
    pd_step_if pop_if ();   // FIFO to sequencer

    pd_csr_axil pd_csr_axil_inst (
        .i_aon_clk        (i_aon_clk),
        .i_soc_pwr_on_rst (i_soc_pwr_on_rst),
        .i_awaddr         (i_awaddr),
        .i_awvalid        (i_awvalid),
        .o_awready        (o_awready),
        .i_wdata          (i_wdata),
        .i_wvalid         (i_wvalid),
        .o_wready         (o_wready),
        .o_bresp          (o_bresp),
        .o_bvalid         (o_bvalid),
        .i_bready         (i_bready),
        .i_araddr         (i_araddr),
        .i_arvalid        (i_arvalid),
        .o_arready        (o_arready),
        .o_rdata          (o_rdata),
        .o_rresp          (o_rresp),
        .o_rvalid         (o_rvalid),
        .i_rready         (i_rready),
        .i_mode           (mode),
        .o_sleep_pulse    (sleep_pulse),
        .o_wake_pulse     (wake_pulse),
        .o_off_delay      (off_delay),
        .o_on_delay       (on_delay)
    );

    pd_mode_fsm pd_mode_fsm_inst (
        .i_aon_clk        (i_aon_clk),
        .i_soc_pwr_on_rst (i_soc_pwr_on_rst),
        .i_sleep_pulse    (sleep_pulse),
        .i_wake_pulse     (wake_pulse),
        .i_off_delay      (off_delay),
        .i_on_delay       (on_delay),
        .o_mode           (mode),
        .i_seq_done       (seq_done),
        .step_if          (push_if)
    );

    pd_step_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) pd_step_fifo_inst (
        .i_aon_clk        (i_aon_clk),
        .i_soc_pwr_on_rst (i_soc_pwr_on_rst),
        .in_if            (push_if),
        .out_if           (pop_if)
    );

    pd_seq_delay pd_seq_delay_inst (
        .i_aon_clk        (i_aon_clk),
        .i_soc_pwr_on_rst (i_soc_pwr_on_rst),
        .step_if          (pop_if),
        .i_pwr_on_ack     (i_pwr_on_ack),
        .o_clk_en         (o_clk_en),
        .o_iso            (o_iso),
        .o_ret            (o_ret),
        .o_rstn           (o_rstn),
        .o_pwr_on_req     (o_pwr_on_req),
        .o_seq_done       (seq_done)
    );

endmodule

// ==== sim/tb_pd_ctrl.sv ====
`timescale 1ns/1ps

module tb_pd_ctrl import pd_pkg::*; ();

    localparam int CLK_PERIOD = 40;
    localparam int NUM_ROUNDS = 6;
    localparam int WD_CYCLES  = 64 * (5 * 17 + 8) * 2; // 64 transitions with 2x margin

    // Output vector is {clk_en, iso, ret, rstn, pwr_req}
    localparam logic [4:0] OFF_OUTS = 5'b01100;
    localparam logic [4:0] ON_LVL   = 5'b10011; // On step i sets bit i
    localparam logic [4:0] OFF_LVL  = 5'b00110; // Off step i sets bit 4-i

    logic       i_aon_clk = 1'b0;
    logic       i_soc_pwr_on_rst;
    axil_addr_t i_awaddr;
    logic       i_awvalid;
    logic       o_awready;
    axil_data_t i_wdata;
    logic       i_wvalid;
    logic       o_wready;
    logic [1:0] o_bresp;
    logic       o_bvalid;
    logic       i_bready;
    axil_addr_t i_araddr;
    logic       i_arvalid;
    logic       o_arready;
    axil_data_t o_rdata;
    logic [1:0] o_rresp;
    logic       o_rvalid;
    logic       i_rready;
    logic       i_pwr_on_ack = 1'b0;
    logic       o_clk_en;
    logic       o_iso;
    logic       o_ret;
    logic       o_rstn;
    logic       o_pwr_on_req;

    logic [4:0]  outs;
    logic [4:0]  prev_outs;
    logic [4:0]  exp_next;
    logic [4:0]  exp_seq [5];
    logic        chg;
    int          chg_cnt = 0;
    int          exp_base = -16; // Nothing armed yet
    int          seq_pos;
    logic [7:0]  gap;
    logic [7:0]  min_gap = 8'd1;
    logic [31:0] lfsr = 32'h923b;
    logic [7:0]  ack_draw;
    logic [3:0]  ack_cnt;
    int          chk_errs = 0;
    int          tmo_errs = 0;

    pd_ctrl_top #(.FIFO_DEPTH(8)) pd_ctrl_top_inst (.*);

    always #(CLK_PERIOD / 2) i_aon_clk = ~i_aon_clk;

    assign outs     = {o_clk_en, o_iso, o_ret, o_rstn, o_pwr_on_req};
    assign chg      = (outs != prev_outs);
    assign seq_pos  = chg_cnt - exp_base;
    assign exp_next = (seq_pos >= 0 && seq_pos < 5) ? exp_seq[seq_pos[2:0]] : prev_outs;

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        next_lfsr = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = next_lfsr(lfsr); // One step per bit
        end
    endtask

    // Gap counts edges since the last output change
    always @(posedge i_aon_clk) begin
        prev_outs <= outs;
        if (i_soc_pwr_on_rst) begin
            gap <= 8'hff;
        end else if (chg) begin
            chg_cnt <= chg_cnt + 1;
            gap     <= 8'd1;
        end else if (gap != 8'hff) begin
            gap <= gap + 8'd1;
        end
    end

    // Power switch model with a random settle time of 1 to 8 cycles
    always @(posedge i_aon_clk) begin
        if (i_soc_pwr_on_rst) begin
            i_pwr_on_ack <= 1'b0;
            ack_cnt      <= '0;
        end else if (ack_cnt != '0) begin
            if (ack_cnt == 4'd1) i_pwr_on_ack <= o_pwr_on_req;
            ack_cnt <= ack_cnt - 4'd1;
        end else if (o_pwr_on_req != i_pwr_on_ack) begin
            take_bits(3, ack_draw);
            ack_cnt <= ack_draw[3:0] + 4'd1;
        end
    end

    assert property (@(posedge i_aon_clk) disable iff (i_soc_pwr_on_rst)
        !o_iso |-> (o_pwr_on_req && i_pwr_on_ack))
    else begin
        chk_errs++;
        $display("CHECK FAILED: o_iso=0 with o_pwr_on_req=%h i_pwr_on_ack=%h",
                 $sampled(o_pwr_on_req), $sampled(i_pwr_on_ack));
    end

    assert property (@(posedge i_aon_clk) disable iff (i_soc_pwr_on_rst)
        o_clk_en |-> (o_rstn && !o_iso))
    else begin
        chk_errs++;
        $display("CHECK FAILED: o_clk_en=1 with o_rstn=%h o_iso=%h",
                 $sampled(o_rstn), $sampled(o_iso));
    end

    assert property (@(posedge i_aon_clk) disable iff (i_soc_pwr_on_rst)
        chg |-> (outs == exp_next))
    else begin
        chk_errs++;
        $display("CHECK FAILED: outputs got %h expected %h",
                 $sampled(outs), $sampled(exp_next));
    end

    assert property (@(posedge i_aon_clk) disable iff (i_soc_pwr_on_rst)
        chg |-> (gap >= min_gap))
    else begin
        chk_errs++;
        $display("CHECK FAILED: step gap got %h expected at least %h",
                 $sampled(gap), $sampled(min_gap));
    end

    // Steps after a switch request wait for the acknowledge
    assert property (@(posedge i_aon_clk) disable iff (i_soc_pwr_on_rst)
        (chg && (outs[0] == prev_outs[0])) |-> (i_pwr_on_ack == prev_outs[0]))
    else begin
        chk_errs++;
        $display("CHECK FAILED: i_pwr_on_ack got %h expected %h",
                 $sampled(i_pwr_on_ack), $sampled(prev_outs[0]));
    end

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp)
        else begin
            chk_errs++;
            $display("CHECK FAILED: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic axil_write(input axil_addr_t addr, input axil_data_t data);
        @(posedge i_aon_clk);
        i_awaddr  <= addr;
        i_wdata   <= data;
        i_awvalid <= 1'b1;
        i_wvalid  <= 1'b1;
        i_bready  <= 1'b1;
        @(posedge i_aon_clk);
        while (!(o_awready && o_wready)) @(posedge i_aon_clk);
        i_awvalid <= 1'b0;
        i_wvalid  <= 1'b0;
        @(posedge i_aon_clk);
        while (!o_bvalid) @(posedge i_aon_clk);
        expect_eq("o_bresp", o_bresp, 0);
        i_bready <= 1'b0;
    endtask

    task automatic axil_read(input axil_addr_t addr, output axil_data_t data);
        @(posedge i_aon_clk);
        i_araddr  <= addr;
        i_arvalid <= 1'b1;
        i_rready  <= 1'b1;
        @(posedge i_aon_clk);
        while (!o_arready) @(posedge i_aon_clk);
        i_arvalid <= 1'b0;
        @(posedge i_aon_clk);
        while (!o_rvalid) @(posedge i_aon_clk);
        data = o_rdata;
        expect_eq("o_rresp", o_rresp, 0);
        i_rready <= 1'b0;
    endtask

    task automatic wait_for_mode(input pd_mode_t target);
        axil_data_t rd;
        rd = '1;
        while (rd[1:0] != target) axil_read(REG_STATUS, rd);
    endtask

    // Load the five expected output vectors of the next transition
    task automatic arm_sequence(input logic going_on, input seq_delay_t d);
        logic [4:0] v;
        v = outs;
        for (int i = 0; i < 5; i++) begin
            if (going_on) begin
                v[i] = ON_LVL[i];
            end else begin
                v[4 - i] = OFF_LVL[i];
            end
            exp_seq[i] <= v;
        end
        exp_base <= chg_cnt;
        min_gap  <= {4'd0, d} + 8'd1;
    endtask

    task automatic finish_run;
        $display("errors: checks=%0d timeouts=%0d", chk_errs, tmo_errs);
        if (chk_errs == 0 && tmo_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    initial begin
        #(WD_CYCLES * CLK_PERIOD);
        tmo_errs++;
        $display("Watchdog expired before the tests completed");
        finish_run();
    end

    initial begin
        axil_data_t rd;
        logic [7:0] draw;
        seq_delay_t off_d;
        seq_delay_t on_d;
        i_soc_pwr_on_rst = 1'b1;
        i_awaddr  = '0;
        i_awvalid = 1'b0;
        i_wdata   = '0;
        i_wvalid  = 1'b0;
        i_bready  = 1'b0;
        i_araddr  = '0;
        i_arvalid = 1'b0;
        i_rready  = 1'b0;
        repeat (8) @(posedge i_aon_clk);
        i_soc_pwr_on_rst <= 1'b0;
        @(posedge i_aon_clk);

        expect_eq("outputs", outs, OFF_OUTS); // Domain off and clamped
        expect_eq("o_awready", o_awready, 1);
        expect_eq("o_wready", o_wready, 1);
        expect_eq("o_arready", o_arready, 1);
        expect_eq("o_bvalid", o_bvalid, 0);
        expect_eq("o_rvalid", o_rvalid, 0);
        axil_read(REG_STATUS, rd);
        expect_eq("status", rd, MODE_OFF);

        axil_write(REG_DELAY, 32'h0000_00a5);
        axil_read(REG_DELAY, rd);
        expect_eq("delay", rd, 32'h0000_00a5);
        axil_read(4'hc, rd);
        expect_eq("unmapped", rd, 0);
        axil_read(REG_CTRL, rd);
        expect_eq("ctrl", rd, 0);

        for (int r = 0; r < NUM_ROUNDS; r++) begin
            take_bits(4, draw);
            off_d = draw[3:0];
            take_bits(4, draw);
            on_d = draw[3:0];
            axil_write(REG_DELAY, {24'd0, on_d, off_d});

            // Wake with a stray request while it runs
            arm_sequence(1'b1, on_d);
            axil_write(REG_CTRL, 32'h2);
            axil_write(REG_CTRL, (r % 2 == 0) ? 32'h2 : 32'h1);
            axil_read(REG_STATUS, rd);
            expect_eq("status", rd, MODE_GOING_ON);
            wait_for_mode(MODE_ON);
            expect_eq("outputs", outs, ON_LVL);
            expect_eq("i_pwr_on_ack", i_pwr_on_ack, 1);
            expect_eq("step count", chg_cnt - exp_base, 5);

            axil_write(REG_CTRL, 32'h2); // Already on
            repeat (40) @(posedge i_aon_clk);
            axil_read(REG_STATUS, rd);
            expect_eq("status", rd, MODE_ON);

            // Sleep
            arm_sequence(1'b0, off_d);
            axil_write(REG_CTRL, 32'h1);
            axil_write(REG_CTRL, (r % 2 == 0) ? 32'h1 : 32'h2);
            axil_read(REG_STATUS, rd);
            expect_eq("status", rd, MODE_GOING_OFF);
            wait_for_mode(MODE_OFF);
            expect_eq("outputs", outs, OFF_OUTS);
            expect_eq("i_pwr_on_ack", i_pwr_on_ack, 0);
            expect_eq("step count", chg_cnt - exp_base, 5);

            axil_write(REG_CTRL, 32'h1); // Already off
            repeat (40) @(posedge i_aon_clk);
            axil_read(REG_STATUS, rd);
            expect_eq("status", rd, MODE_OFF);
        end

        finish_run();
    end

endmodule

// ==== sources.f ====
source/pd_pkg.sv
source/pd_step_if.sv
source/pd_csr_axil.sv
source/pd_mode_fsm.sv
source/pd_step_fifo.sv
source/pd_seq_delay.sv
source/pd_ctrl_top.sv
sim/tb_pd_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the power-domain sequencer testbench with Verilator and run it.
# The exit status is nonzero unless the run prints the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_pd_ctrl -f sources.f &&
./obj_dir/Vtb_pd_ctrl | tee /dev/stderr | grep -qx "STATUS: PASS" &&
echo "run_sim: simulation passed" ||
{ echo "run_sim: simulation failed"; exit 1; }
